// ==== tb.f ====
+incdir+hw
hw/secv_pkg.sv
hw/csr_pkg.sv
hw/csr_access.sv
hw/csr_counters.sv
hw/csr_regs.sv
hw/csr_unit.sv
tests/tb_clkgen.sv
tests/csr_unit_chk.sv
tests/csr_unit_tb.sv

// ==== Makefile ====
# Verilator build and run of the CSR unit testbench
SRCS := $(filter-out +%,$(shell cat tb.f)) hw/secv_defs.svh

obj_dir/Vcsr_unit_tb: tb.f $(SRCS)
	verilator --binary --timing --assert -f tb.f --top-module csr_unit_tb -Mdir obj_dir

.PHONY: run check clean

run: obj_dir/Vcsr_unit_tb
	./obj_dir/Vcsr_unit_tb 2>&1 | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

check:
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tests/csr_unit_tb.sv ====
// Directed testbench for the CSR unit covering register access, illegal accesses, traps and counters
`timescale 1ns/1ps
`include "secv_defs.svh"

module csr_unit_tb import secv_pkg::*, csr_pkg::*; ();
    logic                 clk;
    logic                 rst;
    logic [`HARTID_W-1:0] hartid;
    priv_mode_t           priv;
    csr_req_t             req;
    trap_evt_t            trap;
    ivec_t                pend;      // Pending interrupt lines
    logic                 retire;
    logic [`XLEN-1:0]     rdata;
    logic                 illegal;
    logic [`XLEN-1:0]     trap_vec;
    logic                 intr_ena;
    ivec_t                ena_vec;

    logic [31:0] lfsr = 32'h9847;
    logic [63:0] cyc = 64'h0;       // Rising edges since time zero
    logic [63:0] stamp;             // cyc at the last CSR sample
    logic [63:0] scratch;           // Expected mscratch
    int          errors = 0;
    int          checks = 0;
    string       test_name;

    tb_clkgen u_clk (.clk_o(clk), .rst_o(rst));

    csr_unit UUT (
        .clk_i(clk), .rst_i(rst), .hartid_i(hartid), .priv_i(priv),
        .csr_req_i(req), .trap_i(trap), .intr_pend_i(pend), .retire_i(retire),
        .rdata_o(rdata), .illegal_o(illegal), .trap_vec_o(trap_vec),
        .intr_ena_o(intr_ena), .intr_ena_vec_o(ena_vec)
    );

    bind csr_unit csr_unit_chk u_chk (
        .clk_i(clk_i), .rst_i(rst_i), .illegal_i(illegal_o), .we_i(csr_we),
        .adr_i(csr_adr), .trap_i(trap_i), .intr_ena_i(intr_ena_o), .mcycle_i(mcycle),
        .regs_i({u_regs.mstatus, u_regs.mie, u_regs.mtvec, u_regs.mcounteren,
                 u_regs.mscratch, u_regs.mepc, u_regs.mcause, u_regs.mtval})
    );

    always @(posedge clk) cyc <= cyc + 64'd1;

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand64();
        logic [63:0] r;
        int          i;
        r = 64'h0;
        for (i = 0; i < 64; i++)
            r = {r[62:0], lfsr_bit()};  // One step per bit
        return r;
    endfunction

    task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s %s: expected %b actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic wait_cycles(input int n);
        int k;
        for (k = 0; k < n; k++)
            @(negedge clk);
    endtask

    // One instruction driven on the falling edge and sampled mid-cycle
    task automatic csr_cmd(input csr_op_t op, input logic [11:0] adr, input logic [63:0] src,
                           input logic zero, output logic [63:0] rd, output logic ill);
        @(negedge clk);
        req.valid    = 1'b1;
        req.op       = op;
        req.adr      = adr;
        req.src      = src;
        req.src_zero = zero;
        #20;                   // Settled well before the rising edge
        rd    = rdata;
        ill   = illegal;
        stamp = cyc;
        @(negedge clk);        // Write landed on the edge in between
        req = '0;
    endtask

    // csrrs with x0 reads without writing
    task automatic read_expect(input string what, input logic [11:0] adr,
                               input logic [63:0] exp);
        logic [63:0] rd;
        logic        ill;
        csr_cmd(CSR_OP_SET, adr, 64'h0, 1'b1, rd, ill);
        check_bit({what, " illegal"}, 1'b0, ill);
        check_val(what, exp, rd);
    endtask

    task automatic pulse_trap(input trap_evt_t evt, output logic [63:0] vec);
        @(negedge clk);
        trap = evt;
        #20;
        vec = trap_vec;        // Vector is valid during the pulse
        @(negedge clk);
        trap = '0;
    endtask

    task automatic test_reset();
        test_name = "reset";
        check_bit("illegal idle", 1'b0, illegal);
        check_bit("intr_ena", 1'b0, intr_ena);
        check_val("ena_vec", 64'h0, {61'h0, ena_vec});
        read_expect("mstatus", CSR_ADR_MSTATUS, 64'h0);
        read_expect("mie", CSR_ADR_MIE, 64'h0);
        read_expect("mtvec", CSR_ADR_MTVEC, 64'h0);
        read_expect("mepc", CSR_ADR_MEPC, 64'h0);
        read_expect("mcause", CSR_ADR_MCAUSE, 64'h0);
        // MXL=2, U at bit 20, I at bit 8
        read_expect("misa", CSR_ADR_MISA, {2'b10, 36'h0, 5'h0, 1'b1, 11'h0, 1'b1, 8'h0});
        read_expect("mvendorid", CSR_ADR_MVENDORID, `MVENDORID);
        read_expect("marchid", CSR_ADR_MARCHID, `MARCHID);
        read_expect("mimpid", CSR_ADR_MIMPID, `MIMPID);
        read_expect("mhartid", CSR_ADR_MHARTID, {60'h0, hartid});
    endtask

    task automatic test_rmw();
        logic [63:0] v;
        logic [63:0] rd;
        logic        ill;
        test_name = "rmw";
        scratch = 64'h0;
        v = rand64();
        csr_cmd(CSR_OP_WRITE, CSR_ADR_MSCRATCH, v, 1'b0, rd, ill);
        check_val("write old", scratch, rd);
        scratch = v;
        v = rand64();
        csr_cmd(CSR_OP_SET, CSR_ADR_MSCRATCH, v, 1'b0, rd, ill);
        check_val("set old", scratch, rd);
        scratch = scratch | v;
        v = rand64();
        csr_cmd(CSR_OP_CLEAR, CSR_ADR_MSCRATCH, v, 1'b0, rd, ill);
        check_val("clear old", scratch, rd);
        scratch = scratch & ~v;
        read_expect("mscratch", CSR_ADR_MSCRATCH, scratch);
        csr_cmd(CSR_OP_SET, CSR_ADR_MSCRATCH, rand64(), 1'b1, rd, ill);  // Zero source index
        read_expect("mscratch after zero-src set", CSR_ADR_MSCRATCH, scratch);
        csr_cmd(CSR_OP_WRITE, CSR_ADR_MSTATUS, '1, 1'b0, rd, ill);
        read_expect("mstatus mask", CSR_ADR_MSTATUS, 64'h88);     // mpie, mie
        csr_cmd(CSR_OP_WRITE, CSR_ADR_MSTATUS, 64'h0, 1'b0, rd, ill);
        read_expect("mstatus cleared", CSR_ADR_MSTATUS, 64'h0);
        csr_cmd(CSR_OP_WRITE, CSR_ADR_MIE, '1, 1'b0, rd, ill);
        read_expect("mie mask", CSR_ADR_MIE, 64'h888);            // meie, mtie, msie
        csr_cmd(CSR_OP_WRITE, CSR_ADR_MIE, 64'h0, 1'b0, rd, ill);
        csr_cmd(CSR_OP_WRITE, CSR_ADR_MTVEC, '1, 1'b0, rd, ill);
        read_expect("mtvec mask", CSR_ADR_MTVEC, 64'hFFFF_FFFF_FFFF_FFFD);
    endtask

    task automatic test_illegal();
        logic [63:0] rd;
        logic        ill;
        test_name = "illegal";
        csr_cmd(CSR_OP_WRITE, CSR_ADR_MVENDORID, rand64(), 1'b0, rd, ill);
        check_bit("mvendorid write", 1'b1, ill);
        csr_cmd(CSR_OP_SET, 12'h3A0, 64'h0, 1'b1, rd, ill);       // pmpcfg0 is absent
        check_bit("unimplemented read", 1'b1, ill);
        priv = PRIV_MODE_USER;
        csr_cmd(CSR_OP_WRITE, CSR_ADR_MSCRATCH, rand64(), 1'b0, rd, ill);
        check_bit("user mode write", 1'b1, ill);
        priv = PRIV_MODE_MACHINE;
        read_expect("mscratch kept", CSR_ADR_MSCRATCH, scratch);
    endtask

    task automatic test_exception();
        trap_evt_t   evt;
        logic [63:0] pc;
        logic [63:0] adr;
        logic [63:0] vec;
        logic [63:0] rd;
        logic        ill;
        test_name = "exception";
        csr_cmd(CSR_OP_WRITE, CSR_ADR_MTVEC, 64'h8000_1000, 1'b0, rd, ill);  // Direct mode
        csr_cmd(CSR_OP_WRITE, CSR_ADR_MSTATUS, 64'h8, 1'b0, rd, ill);
        check_bit("mie before trap", 1'b1, intr_ena);
        pc  = rand64() & ~64'h3;
        adr = rand64();
        evt = '0;
        evt.ex       = 1'b1;
        evt.ex_cause = EX_CAUSE_LOAD_FAULT;
        evt.pc       = pc;
        evt.adr      = adr;
        pulse_trap(evt, vec);
        check_val("trap vector", 64'h8000_1000, vec);
        check_bit("intr_ena after trap", 1'b0, intr_ena);
        read_expect("mepc", CSR_ADR_MEPC, pc);
        read_expect("mcause", CSR_ADR_MCAUSE, 64'd5);
        read_expect("mtval", CSR_ADR_MTVAL, adr);
        csr_cmd(CSR_OP_SET, CSR_ADR_MSTATUS, 64'h0, 1'b1, rd, ill);
        check_val("mstatus mpie/mie", 64'h80, rd & 64'h88);
        evt.ex_cause = EX_CAUSE_ILLEGAL_INSTR;                   // No address for this one
        evt.adr      = rand64();
        pulse_trap(evt, vec);
        read_expect("mcause illegal instr", CSR_ADR_MCAUSE, 64'd2);
        read_expect("mtval illegal instr", CSR_ADR_MTVAL, 64'h0);
    endtask

    task automatic test_interrupt();
        trap_evt_t   evt;
        logic [63:0] pc;
        logic [63:0] vec;
        logic [63:0] rd;
        logic        ill;
        test_name = "interrupt";
        csr_cmd(CSR_OP_WRITE, CSR_ADR_MTVEC, 64'h8000_2001, 1'b0, rd, ill);  // Vectored
        csr_cmd(CSR_OP_WRITE, CSR_ADR_MSTATUS, 64'h8, 1'b0, rd, ill);
        csr_cmd(CSR_OP_WRITE, CSR_ADR_MIE, 64'h80, 1'b0, rd, ill);
        check_val("ena_vec timer", {61'h0, 3'b010}, {61'h0, ena_vec});
        pend = 3'b101;
        read_expect("mip ext+sw", CSR_ADR_MIP, 64'h808);
        pend = 3'b010;
        read_expect("mip timer", CSR_ADR_MIP, 64'h80);
        pc  = rand64() & ~64'h3;
        evt = '0;
        evt.intr       = 1'b1;
        evt.intr_cause = INTR_CAUSE_MTI;
        evt.pc         = pc;
        pulse_trap(evt, vec);
        check_val("vectored target", 64'h8000_2000 + 64'd28, vec);  // Base + 4 * 7
        check_bit("intr_ena after interrupt", 1'b0, intr_ena);
        read_expect("mcause", CSR_ADR_MCAUSE, {1'b1, 59'h0, 4'd7});
        read_expect("mepc", CSR_ADR_MEPC, pc);
        evt = '0;
        evt.mret = 1'b1;
        pulse_trap(evt, vec);
        check_bit("intr_ena after mret", 1'b1, intr_ena);
        csr_cmd(CSR_OP_SET, CSR_ADR_MSTATUS, 64'h0, 1'b1, rd, ill);
        check_val("mstatus after mret", 64'h88, rd & 64'h88);
        read_expect("mepc after mret", CSR_ADR_MEPC, pc);
        csr_cmd(CSR_OP_WRITE, CSR_ADR_MIE, 64'h808, 1'b0, rd, ill);
        check_val("ena_vec ext+sw", {61'h0, 3'b101}, {61'h0, ena_vec});
        pend = '0;
    endtask

    task automatic test_counters();
        logic [63:0] c1;
        logic [63:0] c2;
        logic [63:0] s1;
        logic [63:0] n;
        logic [63:0] v;
        logic        ill;
        int          k;
        test_name = "counters";
        csr_cmd(CSR_OP_SET, CSR_ADR_MCYCLE, 64'h0, 1'b1, c1, ill);
        s1 = stamp;
        wait_cycles(7);
        csr_cmd(CSR_OP_SET, CSR_ADR_MCYCLE, 64'h0, 1'b1, c2, ill);
        check_val("mcycle delta", stamp - s1, c2 - c1);
        csr_cmd(CSR_OP_SET, CSR_ADR_MINSTRET, 64'h0, 1'b1, c1, ill);
        n = 64'h0;
        for (k = 0; k < 24; k++) begin
            @(negedge clk);
            retire = lfsr_bit();   // Random retire pattern
            if (retire)
                n = n + 64'd1;
        end
        @(negedge clk);
        retire = 1'b0;
        csr_cmd(CSR_OP_SET, CSR_ADR_MINSTRET, 64'h0, 1'b1, c2, ill);
        check_val("minstret delta", n, c2 - c1);
        v = rand64();
        csr_cmd(CSR_OP_WRITE, CSR_ADR_MCYCLE, v, 1'b0, c1, ill);
        s1 = stamp;
        csr_cmd(CSR_OP_SET, CSR_ADR_MCYCLE, 64'h0, 1'b1, c2, ill);
        check_val("mcycle load", v + (stamp - s1 - 64'd1), c2);  // Loaded one edge after s1
    endtask

    initial begin
        int n;
        hartid = 4'h5;
        priv   = PRIV_MODE_MACHINE;
        req    = '0;
        trap   = '0;
        pend   = '0;
        retire = 1'b0;
        n = 0;
        while (rst !== 1'b0 && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (rst !== 1'b0) begin
            $display("ERROR: reset still asserted after %0d cycles", n);
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            test_reset();
            test_rmw();
            test_illegal();
            test_exception();
            test_interrupt();
            test_counters();
            $display("Checks: %0d, errors: %0d", checks, errors);
            if (errors == 0)
                $display("Simulation finished: PASS");
            else
                $display("Simulation finished: FAIL");
            $finish;
        end
    end
endmodule

// ==== tests/csr_unit_chk.sv ====
// Concurrent checks on illegal accesses, trap entry and the cycle counter of the CSR unit
`timescale 1ns/1ps
`include "secv_defs.svh"

module csr_unit_chk import csr_pkg::*; (
    input logic               clk_i,
    input logic               rst_i,
    input logic               illegal_i,
    input logic               we_i,        // Register write enable after gating
    input csr_adr_t           adr_i,
    input trap_evt_t          trap_i,
    input logic               intr_ena_i,
    input logic [`XLEN-1:0]   mcycle_i,
    input logic [8*`XLEN-1:0] regs_i       // Trap setup and handling registers
);
    // Faulting access leaves every register as it was
    a_illegal_no_change: assert property (@(posedge clk_i) disable iff (rst_i)
        (illegal_i && !(trap_i.ex || trap_i.intr || trap_i.mret)) |=> $stable(regs_i))
        else $error("register changed on an illegal CSR access");

    // Handler entered with interrupts off
    a_trap_disables: assert property (@(posedge clk_i) disable iff (rst_i)
        (trap_i.ex || trap_i.intr) |=> !intr_ena_i)
        else $error("global interrupt enable still set after a trap");

    // Free-running unless software loads it
    a_mcycle_step: assert property (@(posedge clk_i) disable iff (rst_i)
        !(we_i && adr_i == CSR_ADR_MCYCLE) |=> mcycle_i == $past(mcycle_i) + 64'd1)
        else $error("mcycle did not advance by one");
endmodule

// ==== tests/tb_clkgen.sv ====
// Testbench clock and reset source: 100 ns clock, reset held for the first two cycles
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk_o,
    output logic rst_o
);
    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;  // 100 ns period
    end

    initial begin
        rst_o = 1'b1;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;  // Released on a falling edge
    end
endmodule

// ==== hw/csr_unit.sv ====
// Machine-mode CSR unit: access logic, trap registers and counters of one RV64 hart
`timescale 1ns/1ps
`include "secv_defs.svh"

module csr_unit import secv_pkg::*, csr_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic [`HARTID_W-1:0] hartid_i,
    input  priv_mode_t           priv_i,
    input  csr_req_t             csr_req_i,      // From decoder, one cycle
    input  trap_evt_t            trap_i,         // From core, pulses
    input  ivec_t                intr_pend_i,
    input  logic                 retire_i,
    output logic [`XLEN-1:0]     rdata_o,
    output logic                 illegal_o,
    output logic [`XLEN-1:0]     trap_vec_o,
    output logic                 intr_ena_o,
    output ivec_t                intr_ena_vec_o
);
    csr_adr_t         csr_adr;
    logic             csr_we;
    logic [`XLEN-1:0] csr_wdat;
    logic [`XLEN-1:0] csr_old;   // Read mux result
    logic             csr_hit;
    logic [`XLEN-1:0] mcycle;
    logic [`XLEN-1:0] minstret;

    csr_access u_access (
        .req_i(csr_req_i), .priv_i(priv_i), .old_dat_i(csr_old), .hit_i(csr_hit),
        .adr_o(csr_adr), .we_o(csr_we), .wdat_o(csr_wdat),
        .rdata_o(rdata_o), .illegal_o(illegal_o)
    );

    csr_regs u_regs (
        .clk_i(clk_i), .rst_i(rst_i), .hartid_i(hartid_i),
        .adr_i(csr_adr), .we_i(csr_we), .wdat_i(csr_wdat),
        .trap_i(trap_i), .intr_pend_i(intr_pend_i),
        .mcycle_i(mcycle), .minstret_i(minstret),
        .dat_o(csr_old), .hit_o(csr_hit), .trap_vec_o(trap_vec_o),
        .intr_ena_o(intr_ena_o), .intr_ena_vec_o(intr_ena_vec_o)
    );

    csr_counters u_counters (
        .clk_i(clk_i), .rst_i(rst_i), .retire_i(retire_i),
        .adr_i(csr_adr), .we_i(csr_we), .wdat_i(csr_wdat),
        .mcycle_o(mcycle), .minstret_o(minstret)
    );
endmodule

// ==== hw/csr_regs.sv ====
// Machine trap setup and trap handling registers with trap vector and CSR read multiplexer
`timescale 1ns/1ps
`include "secv_defs.svh"

module csr_regs import secv_pkg::*, csr_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic [`HARTID_W-1:0] hartid_i,
    input  csr_adr_t             adr_i,
    input  logic                 we_i,
    input  logic [`XLEN-1:0]     wdat_i,
    input  trap_evt_t            trap_i,
    input  ivec_t                intr_pend_i,
    input  logic [`XLEN-1:0]     mcycle_i,
    input  logic [`XLEN-1:0]     minstret_i,
    output logic [`XLEN-1:0]     dat_o,          // Old value of the addressed CSR
    output logic                 hit_o,
    output logic [`XLEN-1:0]     trap_vec_o,
    output logic                 intr_ena_o,     // Global mstatus.mie
    output ivec_t                intr_ena_vec_o
);
    // MXL=2 (RV64), extensions I (bit 8) and U (bit 20)
    localparam logic [`XLEN-1:0] MISA = {2'b10, {(`XLEN-28){1'b0}}, 26'h010_0100};

    mstatus_t         mstatus;
    ireg_t            mie;
    logic [`XLEN-1:0] mtvec;       // Base plus mode in bit 0
    logic [`XLEN-1:0] mcounteren;
    logic [`XLEN-1:0] mscratch;
    logic [`XLEN-1:0] mepc;
    mcause_u          mcause;
    logic [`XLEN-1:0] mtval;
    ireg_t            mip;         // Not stored, mirrors the pending lines

    logic             trap;        // Exception or interrupt taken
    logic             csr_wr;      // Software write not displaced by an event
    logic             mtval_adr;   // Cause carries a data address
    logic [`XLEN-1:0] mtvec_base;

    assign trap      = trap_i.ex | trap_i.intr;
    assign csr_wr    = we_i & ~(trap | trap_i.mret);
    assign mtval_adr = trap_i.ex_cause inside {EX_CAUSE_LOAD_MISALIGNED, EX_CAUSE_LOAD_FAULT,
                                               EX_CAUSE_STORE_MISALIGNED, EX_CAUSE_STORE_FAULT};

    // Trap setup
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mstatus    <= '0;
            mie        <= '0;
            mtvec      <= '0;
            mcounteren <= '0;
        end else if (trap) begin
            mstatus.mpp  <= PRIV_MODE_MACHINE;
            mstatus.mpie <= mstatus.mie;  // Save enable
            mstatus.mie  <= 1'b0;         // Handler runs with interrupts off
        end else if (trap_i.mret) begin
            mstatus.mpp  <= PRIV_MODE_MACHINE;  // Only M-mode exists
            mstatus.mie  <= mstatus.mpie;
            mstatus.mpie <= 1'b1;
        end else if (csr_wr) begin
            case (adr_i)
                CSR_ADR_MSTATUS:
                    mstatus <= (mstatus & ~`MSTATUS_MASK) | (wdat_i & `MSTATUS_MASK);
                CSR_ADR_MIE:        mie        <= wdat_i & `MIE_MASK;
                CSR_ADR_MTVEC:      mtvec      <= wdat_i & `MTVEC_MASK;
                CSR_ADR_MCOUNTEREN: mcounteren <= wdat_i & `MCOUNTEREN_MASK;
                default: ;
            endcase
        end
    end

    // Trap handling, ex before intr
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else if (trap_i.ex) begin
            mepc      <= trap_i.pc;
            mcause.ex <= '{intr: 1'b0, rsv: '0, code: trap_i.ex_cause};
            mtval     <= mtval_adr ? trap_i.adr : '0;  // Faulting address or zero
        end else if (trap_i.intr) begin
            mepc       <= trap_i.pc;
            mcause.irq <= '{intr: 1'b1, rsv: '0, code: trap_i.intr_cause};
            mtval      <= '0;
        end else if (csr_wr) begin
            // mret keeps mepc, mcause and mtval, csr_wr already low then
            case (adr_i)
                CSR_ADR_MSCRATCH: mscratch <= wdat_i;
                CSR_ADR_MEPC:     mepc     <= wdat_i;
                CSR_ADR_MCAUSE:   mcause   <= wdat_i;
                CSR_ADR_MTVAL:    mtval    <= wdat_i;
                default: ;
            endcase
        end
    end

    // Vectored mode only for interrupts: base + 4 * cause
    assign mtvec_base = {mtvec[`XLEN-1:2], 2'b00};

    always_comb begin
        trap_vec_o = mtvec_base;
        if (trap_i.intr && mtvec[0])
            trap_vec_o = mtvec_base + {{(`XLEN-6){1'b0}}, trap_i.intr_cause, 2'b00};
    end

    always_comb begin
        mip     = '0;
        mip.mei = intr_pend_i.mei;
        mip.mti = intr_pend_i.mti;
        mip.msi = intr_pend_i.msi;
    end

    assign intr_ena_o     = mstatus.mie;
    assign intr_ena_vec_o = '{mei: mie.mei, mti: mie.mti, msi: mie.msi};

    // Read side, hit marks every implemented address
    always_comb begin
        hit_o = 1'b1;
        case (adr_i)
            CSR_ADR_MSTATUS:    dat_o = mstatus;
            CSR_ADR_MISA:       dat_o = MISA;
            CSR_ADR_MIE:        dat_o = mie;
            CSR_ADR_MTVEC:      dat_o = mtvec;
            CSR_ADR_MCOUNTEREN: dat_o = mcounteren;
            CSR_ADR_MSCRATCH:   dat_o = mscratch;
            CSR_ADR_MEPC:       dat_o = mepc;
            CSR_ADR_MCAUSE:     dat_o = mcause;
            CSR_ADR_MTVAL:      dat_o = mtval;
            CSR_ADR_MIP:        dat_o = mip;
            CSR_ADR_MCYCLE:     dat_o = mcycle_i;
            CSR_ADR_MINSTRET:   dat_o = minstret_i;
            CSR_ADR_MVENDORID:  dat_o = `MVENDORID;
            CSR_ADR_MARCHID:    dat_o = `MARCHID;
            CSR_ADR_MIMPID:     dat_o = `MIMPID;
            CSR_ADR_MHARTID:    dat_o = {{(`XLEN-`HARTID_W){1'b0}}, hartid_i};
            default: begin
                dat_o = '0;
                hit_o = 1'b0;  // PMP and everything else unimplemented
            end
        endcase
    end
endmodule

// ==== hw/csr_counters.sv ====
// Machine counters: free-running mcycle and retire-driven minstret with software write ports
`timescale 1ns/1ps
`include "secv_defs.svh"

module csr_counters import csr_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             retire_i,    // One instruction retired this cycle
    input  csr_adr_t         adr_i,
    input  logic             we_i,
    input  logic [`XLEN-1:0] wdat_i,
    output logic [`XLEN-1:0] mcycle_o,
    output logic [`XLEN-1:0] minstret_o
);
    logic cyc_wr;   // Software load of mcycle
    logic ret_wr;   // Software load of minstret

    assign cyc_wr = we_i && (adr_i == CSR_ADR_MCYCLE);
    assign ret_wr = we_i && (adr_i == CSR_ADR_MINSTRET);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mcycle_o   <= '0;
            minstret_o <= '0;
        end else begin
            // Written value wins over the increment
            if (cyc_wr)
                mcycle_o <= wdat_i;
            else
                mcycle_o <= mcycle_o + `XLEN'(1);

            if (ret_wr)
                minstret_o <= wdat_i;
            else if (retire_i)
                minstret_o <= minstret_o + `XLEN'(1);  // Counts retire pulses only
        end
    end
endmodule

// ==== hw/csr_access.sv ====
// CSR access stage: read-modify-write of one Zicsr instruction and legality check
`timescale 1ns/1ps
`include "secv_defs.svh"

module csr_access import secv_pkg::*, csr_pkg::*; (
    input  csr_req_t         req_i,
    input  priv_mode_t       priv_i,
    input  logic [`XLEN-1:0] old_dat_i,  // Current register value
    input  logic             hit_i,      // Address implemented
    output csr_adr_t         adr_o,
    output logic             we_o,
    output logic [`XLEN-1:0] wdat_o,
    output logic [`XLEN-1:0] rdata_o,    // Instruction result to rd
    output logic             illegal_o
);
    logic active;  // Strobe with a real operation
    logic wr_req;  // Instruction wants to write
    logic ro_adr;  // Top bits 11 mark read-only space

    assign adr_o  = csr_adr_t'(req_i.adr);
    assign active = req_i.valid && (req_i.op != CSR_OP_NONE);
    assign ro_adr = (req_i.adr[11:10] == 2'b11);

    // New value from old value and source
    always_comb begin
        case (req_i.op)
            CSR_OP_WRITE: wdat_o = req_i.src;
            CSR_OP_SET:   wdat_o = old_dat_i | req_i.src;
            CSR_OP_CLEAR: wdat_o = old_dat_i & ~req_i.src;
            default:      wdat_o = old_dat_i;
        endcase
    end

    // csrrw always writes, set/clear with x0 or uimm 0 only read
    assign wr_req = active && ((req_i.op == CSR_OP_WRITE) || !req_i.src_zero);

    assign illegal_o = active && (!hit_i                          // Unimplemented
                                  || (ro_adr && wr_req)           // Write to read-only
                                  || (priv_i != PRIV_MODE_MACHINE));

    assign we_o    = wr_req && !illegal_o;  // Nothing lands on a fault
    assign rdata_o = old_dat_i;
endmodule

// ==== hw/csr_pkg.sv ====
// CSR unit types: implemented addresses, mstatus and interrupt layouts, mcause views, trap event
`include "secv_defs.svh"

package csr_pkg;
    import secv_pkg::*;

    // Implemented machine-mode CSRs
    typedef enum logic [11:0] {
        CSR_ADR_MSTATUS    = 12'h300,
        CSR_ADR_MISA       = 12'h301,
        CSR_ADR_MIE        = 12'h304,
        CSR_ADR_MTVEC      = 12'h305,
        CSR_ADR_MCOUNTEREN = 12'h306,
        CSR_ADR_MSCRATCH   = 12'h340,
        CSR_ADR_MEPC       = 12'h341,
        CSR_ADR_MCAUSE     = 12'h342,
        CSR_ADR_MTVAL      = 12'h343,
        CSR_ADR_MIP        = 12'h344,
        CSR_ADR_MCYCLE     = 12'hB00,
        CSR_ADR_MINSTRET   = 12'hB02,
        CSR_ADR_MVENDORID  = 12'hF11,
        CSR_ADR_MARCHID    = 12'hF12,
        CSR_ADR_MIMPID     = 12'hF13,
        CSR_ADR_MHARTID    = 12'hF14
    } csr_adr_t;

    // Only mie, mpie and mpp are kept, the rest reads zero
    typedef struct packed {
        logic [`XLEN-1:13] rsv_hi;
        priv_mode_t        mpp;     // Bits 12:11
        logic [10:8]       rsv_mid;
        logic              mpie;    // Bit 7
        logic [6:4]        rsv_lo;
        logic              mie;     // Bit 3
        logic [2:0]        rsv_uie;
    } mstatus_t;

    // mie / mip layout, machine bits only
    typedef struct packed {
        logic [`XLEN-1:12] rsv_hi;
        logic              mei;     // Bit 11
        logic [10:8]       rsv_mid;
        logic              mti;     // Bit 7
        logic [6:4]        rsv_lo;
        logic              msi;     // Bit 3
        logic [2:0]        rsv_s;
    } ireg_t;

    // Compact interrupt vector for the core
    typedef struct packed {
        logic mei;
        logic mti;
        logic msi;
    } ivec_t;

    typedef struct packed {
        logic             intr;     // Always 0 in this view
        logic [`XLEN-6:0] rsv;
        ex_cause_t        code;
    } mcause_ex_t;

    typedef struct packed {
        logic             intr;     // Always 1 in this view
        logic [`XLEN-6:0] rsv;
        intr_cause_t      code;
    } mcause_irq_t;

    // Same word decoded by the intr bit
    typedef union packed {
        mcause_ex_t  ex;
        mcause_irq_t irq;
    } mcause_u;

    // Trap and return events from the core
    typedef struct packed {
        logic             ex;       // Exception pulse
        logic             intr;     // Interrupt taken pulse
        logic             mret;     // mret retired pulse
        ex_cause_t        ex_cause;
        intr_cause_t      intr_cause;
        logic [`XLEN-1:0] pc;       // PC of the trapping instruction
        logic [`XLEN-1:0] adr;      // Faulting data address
    } trap_evt_t;

endpackage

// ==== hw/secv_pkg.sv ====
// SEC-V core types: privilege mode, trap cause codes, CSR operations and the CSR request
`include "secv_defs.svh"

package secv_pkg;

    // Encoding as in mstatus.mpp
    typedef enum logic [1:0] {
        PRIV_MODE_USER    = 2'b00,
        PRIV_MODE_MACHINE = 2'b11
    } priv_mode_t;

    // Synchronous exception codes (mcause, intr bit clear)
    typedef enum logic [3:0] {
        EX_CAUSE_INSTR_MISALIGNED = 4'd0,
        EX_CAUSE_INSTR_FAULT      = 4'd1,
        EX_CAUSE_ILLEGAL_INSTR    = 4'd2,
        EX_CAUSE_BREAKPOINT       = 4'd3,
        EX_CAUSE_LOAD_MISALIGNED  = 4'd4,
        EX_CAUSE_LOAD_FAULT       = 4'd5,
        EX_CAUSE_STORE_MISALIGNED = 4'd6,
        EX_CAUSE_STORE_FAULT      = 4'd7,
        EX_CAUSE_ECALL_U          = 4'd8,
        EX_CAUSE_ECALL_M          = 4'd11
    } ex_cause_t;

    // Machine interrupt codes, equal to the bit position in mie/mip
    typedef enum logic [3:0] {
        INTR_CAUSE_MSI = 4'd3,  // Software
        INTR_CAUSE_MTI = 4'd7,  // Timer
        INTR_CAUSE_MEI = 4'd11  // External
    } intr_cause_t;

    // Zicsr operations, csrrw / csrrs / csrrc and immediate forms
    typedef enum logic [1:0] {
        CSR_OP_NONE  = 2'd0,
        CSR_OP_WRITE = 2'd1,
        CSR_OP_SET   = 2'd2,
        CSR_OP_CLEAR = 2'd3
    } csr_op_t;

    // Decoded CSR instruction, one-cycle strobe
    typedef struct packed {
        logic             valid;    // Request strobe
        csr_op_t          op;
        logic [11:0]      adr;      // Raw CSR address field
        logic [`XLEN-1:0] src;      // rs1 value or zero-extended uimm
        logic             src_zero; // rs1 index / uimm was zero
    } csr_req_t;

endpackage

// ==== hw/secv_defs.svh ====
// SEC-V core parameters: register width, hart id width, CSR write masks and identity values
`ifndef SECV_DEFS_SVH
`define SECV_DEFS_SVH

// Register width, fixed by RV64
`define XLEN 64

// Bits of the hart id input
`define HARTID_W 4

// Software-writable bits: mpie (7), mie (3)
`define MSTATUS_MASK 64'h0000_0000_0000_0088

// meie (11), mtie (7), msie (3)
`define MIE_MASK 64'h0000_0000_0000_0888

// Everything but bit 1, so only direct (0) and vectored (1) modes exist
`define MTVEC_MASK 64'hFFFF_FFFF_FFFF_FFFD

// CY, TM, IR enables
`define MCOUNTEREN_MASK 64'h0000_0000_0000_0007

// Machine information registers, read-only
`define MVENDORID 64'h0000_0000_0000_0000
`define MARCHID 64'h0000_0000_0000_002A
`define MIMPID 64'h0000_0000_0000_0001

`endif
